// ==== axi_split_pkg.sv ====
/*
 * Shared definitions for the 64-bit to 2 x 32-bit AXI4 splitter
 *   - Address, length and data widths
 *   - FIFO depths and B credit counter width
 *   - Base addresses of the two master ports
 *   - Address-request and half-beat payload types
 */

package axi_split_pkg;

   // ====================
   // Widths and depths
   // ====================
   localparam int ADDR_W     = 32;
   localparam int LEN_W      = 8;
   localparam int DATA_W     = 64;
   // Each master carries one half of a slave beat
   localparam int HALF_W     = DATA_W / 2;
   localparam int AX_DEPTH   = 4;
   localparam int DATA_DEPTH = 8;
   localparam int CREDIT_W   = 8;

   // ====================
   // Types
   // ====================
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [LEN_W-1:0]  len_t;
   typedef logic [DATA_W-1:0] wide_data_t;
   typedef logic [HALF_W-1:0] half_data_t;

   // Master-side window offsets
   localparam addr_t BASE_ADDR0 = 32'h0000_0000;
   localparam addr_t BASE_ADDR1 = 32'h4000_0000;

   // AW/AR FIFO entry with the address in the upper bits
   typedef struct packed {
      addr_t addr;
      len_t  len;
   } ax_req_t;

   // W/R FIFO entry with last in bit 0
   typedef struct packed {
      half_data_t data;
      logic       last;
   } half_beat_t;

endpackage

// ==== axi_split_fifo.sv ====
/*
 * Synchronous FIFO with valid/ready on both sides
 *   - Payload type chosen per instance
 *   - Circular buffer with read/write pointers and an item count
 */

module axi_split_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  DEPTH     = 4
) (
   input  logic     clk,
   input  logic     resetn,
   input  payload_t in_data,
   input  logic     in_valid,
   output logic     in_ready,
   output payload_t out_data,
   output logic     out_valid,
   input  logic     out_ready
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pop;

   // Pointer step that wraps at DEPTH-1 for any depth
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // Not ready while full or held in reset
   assign in_ready  = resetn && (count != CNT_W'(DEPTH));
   assign out_valid = (count != '0);
   assign out_data  = mem[rd_ptr];

   assign push = in_valid && in_ready;
   assign pop  = out_valid && out_ready;

   // Storage array
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_data;
      end
   end

   // Pointers and occupancy
   always_ff @(posedge clk) begin
      if (!resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         // Push and pop together leave the count alone
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Occupancy stays within the buffer
   a_count_bound: assert property (@(posedge clk) disable iff (!resetn)
      count <= CNT_W'(DEPTH))
      else $error("FIFO count above DEPTH");

endmodule

// ==== axi_split_addr_fanout.sv ====
/*
 * Address-channel fan-out for AW and AR
 *   - Halves the slave address and adds each master base
 *   - Pushes both master FIFOs in the same cycle
 */

module axi_split_addr_fanout
   import axi_split_pkg::*;
(
   input  logic    clk,
   input  logic    resetn,
   input  addr_t   s_addr,
   input  len_t    s_len,
   input  logic    s_valid,
   output logic    s_ready,
   output ax_req_t m0_req,
   output ax_req_t m1_req,
   output logic    m0_valid,
   output logic    m1_valid,
   input  logic    m0_ready,
   input  logic    m1_ready
);

   ax_req_t req0;
   ax_req_t req1;
   logic    fifo0_ready;
   logic    fifo1_ready;
   logic    push;

   // Each half-width port sees half the byte offset
   assign req0 = '{addr: (s_addr >> 1) + BASE_ADDR0, len: s_len};
   assign req1 = '{addr: (s_addr >> 1) + BASE_ADDR1, len: s_len};

   // Accept only when both sides have room
   assign s_ready = resetn && fifo0_ready && fifo1_ready;
   assign push    = s_valid && s_ready;

   // ====================
   // Master-side FIFOs
   // ====================
   axi_split_fifo #(.payload_t(ax_req_t), .DEPTH(AX_DEPTH)) fifo0 (
      .clk      (clk),
      .resetn   (resetn),
      .in_data  (req0),
      .in_valid (push),
      .in_ready (fifo0_ready),
      .out_data (m0_req),
      .out_valid(m0_valid),
      .out_ready(m0_ready)
   );

   axi_split_fifo #(.payload_t(ax_req_t), .DEPTH(AX_DEPTH)) fifo1 (
      .clk      (clk),
      .resetn   (resetn),
      .in_data  (req1),
      .in_valid (push),
      .in_ready (fifo1_ready),
      .out_data (m1_req),
      .out_valid(m1_valid),
      .out_ready(m1_ready)
   );

   // Both FIFOs have taken exactly the same requests
   a_joint_push: assert property (@(posedge clk) disable iff (!resetn)
      fifo0.wr_ptr == fifo1.wr_ptr)
      else $error("Address FIFOs pushed in different cycles");

endmodule

// ==== axi_split_wdata_fanout.sv ====
/*
 * Write-data split
 *   - Low half of each beat to master 0, high half to master 1
 *   - Last copied to both halves
 */

module axi_split_wdata_fanout
   import axi_split_pkg::*;
(
   input  logic       clk,
   input  logic       resetn,
   input  wide_data_t s_data,
   input  logic       s_last,
   input  logic       s_valid,
   output logic       s_ready,
   output half_beat_t m0_beat,
   output half_beat_t m1_beat,
   output logic       m0_valid,
   output logic       m1_valid,
   input  logic       m0_ready,
   input  logic       m1_ready
);

   half_beat_t beat0;
   half_beat_t beat1;
   logic       fifo0_ready;
   logic       fifo1_ready;
   logic       push;

   assign beat0 = '{data: s_data[HALF_W-1:0], last: s_last};
   assign beat1 = '{data: s_data[DATA_W-1:HALF_W], last: s_last};

   // Same joint-ready rule as the address path
   assign s_ready = resetn && fifo0_ready && fifo1_ready;
   assign push    = s_valid && s_ready;

   // ====================
   // Half-width FIFOs
   // ====================
   axi_split_fifo #(.payload_t(half_beat_t), .DEPTH(DATA_DEPTH)) fifo0 (
      .clk      (clk),
      .resetn   (resetn),
      .in_data  (beat0),
      .in_valid (push),
      .in_ready (fifo0_ready),
      .out_data (m0_beat),
      .out_valid(m0_valid),
      .out_ready(m0_ready)
   );

   axi_split_fifo #(.payload_t(half_beat_t), .DEPTH(DATA_DEPTH)) fifo1 (
      .clk      (clk),
      .resetn   (resetn),
      .in_data  (beat1),
      .in_valid (push),
      .in_ready (fifo1_ready),
      .out_data (m1_beat),
      .out_valid(m1_valid),
      .out_ready(m1_ready)
   );

endmodule

// ==== axi_split_bresp_merge.sv ====
/*
 * Write-response merge
 *   - One credit counter per master
 *   - One slave response for each pair of master responses
 */

module axi_split_bresp_merge
   import axi_split_pkg::*;
(
   input  logic clk,
   input  logic resetn,
   input  logic m0_b_valid,
   input  logic m1_b_valid,
   input  logic s_b_ready,
   output logic m0_b_ready,
   output logic m1_b_ready,
   output logic s_b_valid
);

   logic [CREDIT_W-1:0] credit [2];
   logic [1:0]          add;
   logic                sub;

   // Masters stall along with the slave
   assign m0_b_ready = s_b_ready;
   assign m1_b_ready = s_b_ready;

   assign add[0] = m0_b_valid && m0_b_ready;
   assign add[1] = m1_b_valid && m1_b_ready;

   // A slave response needs a credit from each side
   assign s_b_valid = (credit[0] != '0) && (credit[1] != '0);
   assign sub       = s_b_valid && s_b_ready;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         credit[0] <= '0;
         credit[1] <= '0;
      end else begin
         for (int i = 0; i < 2; i++) begin
            // Add and remove in one cycle cancel out
            if (add[i] && !sub) begin
               credit[i] <= credit[i] + 1'b1;
            end else if (!add[i] && sub) begin
               credit[i] <= credit[i] - 1'b1;
            end
         end
      end
   end

   // Counters must not roll over on a new master response
   a_no_wrap: assert property (@(posedge clk) disable iff (!resetn)
      !((add[0] && !sub && (&credit[0])) || (add[1] && !sub && (&credit[1]))))
      else $error("B credit counter wrapped");

endmodule

// ==== axi_split_rdata_join.sv ====
/*
 * Read-data join
 *   - Buffers each master's read beats
 *   - Presents a wide beat once both halves are present
 *   - Master 1 data on top, last from master 0
 */

module axi_split_rdata_join
   import axi_split_pkg::*;
(
   input  logic       clk,
   input  logic       resetn,
   input  half_beat_t m0_beat,
   input  half_beat_t m1_beat,
   input  logic       m0_valid,
   input  logic       m1_valid,
   output logic       m0_ready,
   output logic       m1_ready,
   output wide_data_t s_data,
   output logic       s_last,
   output logic       s_valid,
   input  logic       s_ready
);

   half_beat_t head0;
   half_beat_t head1;
   logic       head0_valid;
   logic       head1_valid;
   logic       pop;

   // ====================
   // Per-master FIFOs
   // ====================
   axi_split_fifo #(.payload_t(half_beat_t), .DEPTH(DATA_DEPTH)) fifo0 (
      .clk      (clk),
      .resetn   (resetn),
      .in_data  (m0_beat),
      .in_valid (m0_valid),
      .in_ready (m0_ready),
      .out_data (head0),
      .out_valid(head0_valid),
      .out_ready(pop)
   );

   axi_split_fifo #(.payload_t(half_beat_t), .DEPTH(DATA_DEPTH)) fifo1 (
      .clk      (clk),
      .resetn   (resetn),
      .in_data  (m1_beat),
      .in_valid (m1_valid),
      .in_ready (m1_ready),
      .out_data (head1),
      .out_valid(head1_valid),
      .out_ready(pop)
   );

   // Wide beat only once both halves wait at the heads
   assign s_valid = head0_valid && head1_valid;
   assign s_data  = {head1.data, head0.data};
   assign s_last  = head0.last;

   // Both heads leave together
   assign pop = s_valid && s_ready;

   // Masters must end their bursts on the same beat
   a_last_match: assert property (@(posedge clk) disable iff (!resetn)
      pop |-> (head0.last == head1.last))
      else $error("Read last differs between masters");

endmodule

// ==== axi_split_top.sv ====
/*
 * Splitter top level
 *   - One 64-bit AXI4 slave port, two 32-bit AXI4 master ports
 *   - AW, AR and W fan-out, B merge, R join
 */

module axi_split_top
   import axi_split_pkg::*;
(
   input  logic       clk,
   input  logic       resetn,

   // ====================
   // Slave port
   // ====================
   input  addr_t      s_aw_addr,
   input  len_t       s_aw_len,
   input  logic       s_aw_valid,
   output logic       s_aw_ready,
   input  wide_data_t s_w_data,
   input  logic       s_w_last,
   input  logic       s_w_valid,
   output logic       s_w_ready,
   output logic       s_b_valid,
   input  logic       s_b_ready,
   input  addr_t      s_ar_addr,
   input  len_t       s_ar_len,
   input  logic       s_ar_valid,
   output logic       s_ar_ready,
   output wide_data_t s_r_data,
   output logic       s_r_last,
   output logic       s_r_valid,
   input  logic       s_r_ready,

   // ====================
   // Master port 0
   // ====================
   output addr_t      m0_aw_addr,
   output len_t       m0_aw_len,
   output logic       m0_aw_valid,
   input  logic       m0_aw_ready,
   output half_data_t m0_w_data,
   output logic       m0_w_last,
   output logic       m0_w_valid,
   input  logic       m0_w_ready,
   input  logic       m0_b_valid,
   output logic       m0_b_ready,
   output addr_t      m0_ar_addr,
   output len_t       m0_ar_len,
   output logic       m0_ar_valid,
   input  logic       m0_ar_ready,
   input  half_data_t m0_r_data,
   input  logic       m0_r_last,
   input  logic       m0_r_valid,
   output logic       m0_r_ready,

   // ====================
   // Master port 1
   // ====================
   output addr_t      m1_aw_addr,
   output len_t       m1_aw_len,
   output logic       m1_aw_valid,
   input  logic       m1_aw_ready,
   output half_data_t m1_w_data,
   output logic       m1_w_last,
   output logic       m1_w_valid,
   input  logic       m1_w_ready,
   input  logic       m1_b_valid,
   output logic       m1_b_ready,
   output addr_t      m1_ar_addr,
   output len_t       m1_ar_len,
   output logic       m1_ar_valid,
   input  logic       m1_ar_ready,
   input  half_data_t m1_r_data,
   input  logic       m1_r_last,
   input  logic       m1_r_valid,
   output logic       m1_r_ready
);

   // Struct payloads map onto the loose ports by concatenation
   // ax_req_t is {addr, len}, half_beat_t is {data, last}

   // Write address
   axi_split_addr_fanout aw_fanout (
      .clk     (clk),          .resetn  (resetn),
      .s_addr  (s_aw_addr),    .s_len   (s_aw_len),
      .s_valid (s_aw_valid),   .s_ready (s_aw_ready),
      .m0_req  ({m0_aw_addr, m0_aw_len}),
      .m1_req  ({m1_aw_addr, m1_aw_len}),
      .m0_valid(m0_aw_valid),  .m1_valid(m1_aw_valid),
      .m0_ready(m0_aw_ready),  .m1_ready(m1_aw_ready)
   );

   // Read address
   axi_split_addr_fanout ar_fanout (
      .clk     (clk),          .resetn  (resetn),
      .s_addr  (s_ar_addr),    .s_len   (s_ar_len),
      .s_valid (s_ar_valid),   .s_ready (s_ar_ready),
      .m0_req  ({m0_ar_addr, m0_ar_len}),
      .m1_req  ({m1_ar_addr, m1_ar_len}),
      .m0_valid(m0_ar_valid),  .m1_valid(m1_ar_valid),
      .m0_ready(m0_ar_ready),  .m1_ready(m1_ar_ready)
   );

   // Write data
   axi_split_wdata_fanout w_fanout (
      .clk     (clk),          .resetn  (resetn),
      .s_data  (s_w_data),     .s_last  (s_w_last),
      .s_valid (s_w_valid),    .s_ready (s_w_ready),
      .m0_beat ({m0_w_data, m0_w_last}),
      .m1_beat ({m1_w_data, m1_w_last}),
      .m0_valid(m0_w_valid),   .m1_valid(m1_w_valid),
      .m0_ready(m0_w_ready),   .m1_ready(m1_w_ready)
   );

   // Write response
   axi_split_bresp_merge b_merge (
      .clk       (clk),        .resetn    (resetn),
      .m0_b_valid(m0_b_valid), .m1_b_valid(m1_b_valid),
      .s_b_ready (s_b_ready),
      .m0_b_ready(m0_b_ready), .m1_b_ready(m1_b_ready),
      .s_b_valid (s_b_valid)
   );

   // Read data
   axi_split_rdata_join r_join (
      .clk     (clk),          .resetn  (resetn),
      .m0_beat ({m0_r_data, m0_r_last}),
      .m1_beat ({m1_r_data, m1_r_last}),
      .m0_valid(m0_r_valid),   .m1_valid(m1_r_valid),
      .m0_ready(m0_r_ready),   .m1_ready(m1_r_ready),
      .s_data  (s_r_data),     .s_last  (s_r_last),
      .s_valid (s_r_valid),    .s_ready (s_r_ready)
   );

endmodule

// ==== tb_axi_split.sv ====
/*
 * Testbench for the 64-bit to 2 x 32-bit AXI4 splitter
 *   - Random slave-side AW, W and AR traffic from a Galois LFSR
 *   - Master-side responders for B and R, random back-pressure everywhere
 *   - Queue-based reference model with typed compare tasks
 */

module tb_axi_split
   import axi_split_pkg::*;
();

   localparam int N_WR           = 40;
   localparam int N_RD           = 40;
   localparam int TIMEOUT_CYCLES = 20000;

   logic       clk;
   logic       resetn;
   addr_t      s_aw_addr, s_ar_addr, m0_aw_addr, m1_aw_addr, m0_ar_addr, m1_ar_addr;
   len_t       s_aw_len, s_ar_len, m0_aw_len, m1_aw_len, m0_ar_len, m1_ar_len;
   wide_data_t s_w_data, s_r_data;
   half_data_t m0_w_data, m1_w_data, m0_r_data, m1_r_data;
   logic       s_aw_valid, s_aw_ready, s_ar_valid, s_ar_ready;
   logic       s_w_last, s_w_valid, s_w_ready, s_b_valid, s_b_ready;
   logic       s_r_last, s_r_valid, s_r_ready;
   logic       m0_aw_valid, m0_aw_ready, m1_aw_valid, m1_aw_ready;
   logic       m0_ar_valid, m0_ar_ready, m1_ar_valid, m1_ar_ready;
   logic       m0_w_last, m0_w_valid, m0_w_ready, m1_w_last, m1_w_valid, m1_w_ready;
   logic       m0_b_valid, m0_b_ready, m1_b_valid, m1_b_ready;
   logic       m0_r_last, m0_r_valid, m0_r_ready, m1_r_last, m1_r_valid, m1_r_ready;

   // ====================
   // Reference model state
   // ====================
   ax_req_t    exp_aw0[$];
   ax_req_t    exp_aw1[$];
   ax_req_t    exp_ar0[$];
   ax_req_t    exp_ar1[$];
   half_beat_t exp_w0[$];
   half_beat_t exp_w1[$];
   // Master read beats waiting for their partner half
   half_beat_t got_r0[$];
   half_beat_t got_r1[$];
   // Burst lengths still owed on the slave W side and by each read responder
   len_t       w_lens[$];
   len_t       r_lens0[$];
   len_t       r_lens1[$];
   int         aw_sent, ar_sent, w_beat, r_beat0, r_beat1, b_pend0, b_pend1;
   int         mb_cnt0, mb_cnt1, sb_cnt, sr_cnt, sr_exp, cycles;
   logic       s_aw_fire, s_w_fire, s_ar_fire;
   logic       m0_b_fire, m1_b_fire, m0_r_fire, m1_r_fire;
   logic [31:0] lfsr;

   axi_split_top dut (.*);

   initial clk = 1'b0;
   always #5 clk = ~clk;

   // ====================
   // Random source
   // ====================
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   // ====================
   // Error reporting and compares
   // ====================
   task automatic stop_on_mismatch(input string msg);
      $display("Mismatch at time %0t: %s", $time, msg);
      $display("STATUS: FAIL");
      $fatal(1, "Stopped at the first wrong value");
   endtask

   task automatic stop_on_error(input string msg);
      $display("Error at time %0t: %s", $time, msg);
      $display("STATUS: FAIL");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic check_ax(input string what, input ax_req_t got, input ax_req_t exp);
      if (got !== exp) begin
         stop_on_mismatch($sformatf("%s expected addr %h len %0d, got addr %h len %0d",
            what, exp.addr, exp.len, got.addr, got.len));
      end
   endtask

   task automatic check_half(input string what, input half_beat_t got, input half_beat_t exp);
      if (got !== exp) begin
         stop_on_mismatch($sformatf("%s expected data %h last %b, got data %h last %b",
            what, exp.data, exp.last, got.data, got.last));
      end
   endtask

   task automatic check_wide(input string what, input wide_data_t got, input wide_data_t exp);
      if (got !== exp) begin
         stop_on_mismatch($sformatf("%s expected %h, got %h", what, exp, got));
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         stop_on_mismatch($sformatf("%s expected %b, got %b", what, exp, got));
      end
   endtask

   task automatic check_count(input string what, input int got, input int exp);
      if (got != exp) begin
         stop_on_mismatch($sformatf("%s expected %0d, got %0d", what, exp, got));
      end
   endtask

   // Valid outputs and slave readies stay low while reset is held
   task automatic check_reset_outputs();
      check_flag("s_aw_ready in reset", s_aw_ready, 1'b0);
      check_flag("s_w_ready in reset", s_w_ready, 1'b0);
      check_flag("s_ar_ready in reset", s_ar_ready, 1'b0);
      check_flag("s_b_valid in reset", s_b_valid, 1'b0);
      check_flag("s_r_valid in reset", s_r_valid, 1'b0);
      check_flag("m0_aw_valid in reset", m0_aw_valid, 1'b0);
      check_flag("m1_aw_valid in reset", m1_aw_valid, 1'b0);
      check_flag("m0_w_valid in reset", m0_w_valid, 1'b0);
      check_flag("m1_w_valid in reset", m1_w_valid, 1'b0);
      check_flag("m0_ar_valid in reset", m0_ar_valid, 1'b0);
      check_flag("m1_ar_valid in reset", m1_ar_valid, 1'b0);
   endtask

   // ====================
   // Monitor at the falling edge
   // ====================
   task automatic monitor_cycle();
      half_beat_t h0;
      half_beat_t h1;
      s_aw_fire = s_aw_valid && s_aw_ready;
      s_w_fire  = s_w_valid && s_w_ready;
      s_ar_fire = s_ar_valid && s_ar_ready;
      m0_b_fire = m0_b_valid && m0_b_ready;
      m1_b_fire = m1_b_valid && m1_b_ready;
      m0_r_fire = m0_r_valid && m0_r_ready;
      m1_r_fire = m1_r_valid && m1_r_ready;

      // Master outputs first, so nothing pushed this cycle can match early
      if (m0_aw_valid && m0_aw_ready) begin
         if (exp_aw0.size() == 0)
            stop_on_error("m0 AW request with no slave request behind it");
         else
            check_ax("m0 AW", ax_req_t'{addr: m0_aw_addr, len: m0_aw_len}, exp_aw0.pop_front());
      end
      if (m1_aw_valid && m1_aw_ready) begin
         if (exp_aw1.size() == 0)
            stop_on_error("m1 AW request with no slave request behind it");
         else
            check_ax("m1 AW", ax_req_t'{addr: m1_aw_addr, len: m1_aw_len}, exp_aw1.pop_front());
      end
      if (m0_ar_valid && m0_ar_ready) begin
         if (exp_ar0.size() == 0)
            stop_on_error("m0 AR request with no slave request behind it");
         else
            check_ax("m0 AR", ax_req_t'{addr: m0_ar_addr, len: m0_ar_len}, exp_ar0.pop_front());
         r_lens0.push_back(m0_ar_len);
      end
      if (m1_ar_valid && m1_ar_ready) begin
         if (exp_ar1.size() == 0)
            stop_on_error("m1 AR request with no slave request behind it");
         else
            check_ax("m1 AR", ax_req_t'{addr: m1_ar_addr, len: m1_ar_len}, exp_ar1.pop_front());
         r_lens1.push_back(m1_ar_len);
      end
      if (m0_w_valid && m0_w_ready) begin
         if (exp_w0.size() == 0)
            stop_on_error("m0 W beat with no slave beat behind it");
         else
            check_half("m0 W", half_beat_t'{data: m0_w_data, last: m0_w_last}, exp_w0.pop_front());
         if (m0_w_last) b_pend0++;
      end
      if (m1_w_valid && m1_w_ready) begin
         if (exp_w1.size() == 0)
            stop_on_error("m1 W beat with no slave beat behind it");
         else
            check_half("m1 W", half_beat_t'{data: m1_w_data, last: m1_w_last}, exp_w1.pop_front());
         if (m1_w_last) b_pend1++;
      end

      // Joined read beat with the high half from master 1
      if (s_r_valid && s_r_ready) begin
         if (got_r0.size() == 0 || got_r1.size() == 0) begin
            stop_on_error("slave R beat before both master halves arrived");
         end else begin
            h0 = got_r0.pop_front();
            h1 = got_r1.pop_front();
            check_wide("s R data", s_r_data, {h1.data, h0.data});
            check_flag("s R last", s_r_last, h0.last);
         end
         sr_cnt++;
      end

      // Both master B readies follow the slave
      check_flag("m0 B ready", m0_b_ready, s_b_ready);
      check_flag("m1 B ready", m1_b_ready, s_b_ready);

      // B merge never runs ahead of either master
      if (m0_b_fire) mb_cnt0++;
      if (m1_b_fire) mb_cnt1++;
      if (s_b_valid && s_b_ready) sb_cnt++;
      if (sb_cnt > mb_cnt0 || sb_cnt > mb_cnt1) begin
         stop_on_error("slave B response issued before both master responses");
      end

      // Master R beats wait for their partner
      if (m0_r_fire) begin
         got_r0.push_back(half_beat_t'{data: m0_r_data, last: m0_r_last});
         if (m0_r_last) begin
            r_lens0.delete(0);
            r_beat0 = 0;
         end else begin
            r_beat0++;
         end
      end
      if (m1_r_fire) begin
         got_r1.push_back(half_beat_t'{data: m1_r_data, last: m1_r_last});
         if (m1_r_last) begin
            r_lens1.delete(0);
            r_beat1 = 0;
         end else begin
            r_beat1++;
         end
      end

      // Slave transfers become expected master items
      if (s_aw_fire) begin
         exp_aw0.push_back(ax_req_t'{addr: s_aw_addr / 2 + BASE_ADDR0, len: s_aw_len});
         exp_aw1.push_back(ax_req_t'{addr: s_aw_addr / 2 + BASE_ADDR1, len: s_aw_len});
      end
      if (s_ar_fire) begin
         exp_ar0.push_back(ax_req_t'{addr: s_ar_addr / 2 + BASE_ADDR0, len: s_ar_len});
         exp_ar1.push_back(ax_req_t'{addr: s_ar_addr / 2 + BASE_ADDR1, len: s_ar_len});
         sr_exp += int'(s_ar_len) + 1;
      end
      if (s_w_fire) begin
         exp_w0.push_back(half_beat_t'{data: s_w_data[HALF_W-1:0], last: s_w_last});
         exp_w1.push_back(half_beat_t'{data: s_w_data[DATA_W-1:HALF_W], last: s_w_last});
         if (s_w_last) begin
            w_lens.delete(0);
            w_beat = 0;
         end else begin
            w_beat++;
         end
      end
   endtask

   // ====================
   // Drivers just after the rising edge
   // ====================
   task automatic drive_cycle();
      // New slave requests only once the previous one was taken
      if (!s_aw_valid || s_aw_fire) begin
         s_aw_valid = 1'b0;
         if (aw_sent < N_WR && rand_bits(1) != 0) begin
            s_aw_addr  = rand_bits(32);
            s_aw_len   = len_t'(rand_bits(2));
            s_aw_valid = 1'b1;
            w_lens.push_back(s_aw_len);
            aw_sent++;
         end
      end
      if (!s_w_valid || s_w_fire) begin
         s_w_valid = 1'b0;
         if (w_lens.size() != 0 && rand_bits(1) != 0) begin
            s_w_data  = {rand_bits(32), rand_bits(32)};
            s_w_last  = (w_beat == int'(w_lens[0]));
            s_w_valid = 1'b1;
         end
      end
      if (!s_ar_valid || s_ar_fire) begin
         s_ar_valid = 1'b0;
         if (ar_sent < N_RD && rand_bits(1) != 0) begin
            s_ar_addr  = rand_bits(32);
            s_ar_len   = len_t'(rand_bits(2));
            s_ar_valid = 1'b1;
            ar_sent++;
         end
      end

      // Random back-pressure
      m0_aw_ready = (rand_bits(2) != 0);
      m1_aw_ready = (rand_bits(2) != 0);
      m0_w_ready  = (rand_bits(2) != 0);
      m1_w_ready  = (rand_bits(2) != 0);
      m0_ar_ready = (rand_bits(2) != 0);
      m1_ar_ready = (rand_bits(2) != 0);
      s_b_ready   = (rand_bits(1) != 0);
      s_r_ready   = (rand_bits(2) != 0);

      // One B response per finished write burst
      if (!m0_b_valid || m0_b_fire) begin
         m0_b_valid = 1'b0;
         if (b_pend0 != 0 && rand_bits(1) != 0) begin
            m0_b_valid = 1'b1;
            b_pend0--;
         end
      end
      if (!m1_b_valid || m1_b_fire) begin
         m1_b_valid = 1'b0;
         if (b_pend1 != 0 && rand_bits(1) != 0) begin
            m1_b_valid = 1'b1;
            b_pend1--;
         end
      end

      // len+1 read beats per accepted AR at random times
      if (!m0_r_valid || m0_r_fire) begin
         m0_r_valid = 1'b0;
         if (r_lens0.size() != 0 && rand_bits(1) != 0) begin
            m0_r_data  = rand_bits(32);
            m0_r_last  = (r_beat0 == int'(r_lens0[0]));
            m0_r_valid = 1'b1;
         end
      end
      if (!m1_r_valid || m1_r_fire) begin
         m1_r_valid = 1'b0;
         if (r_lens1.size() != 0 && rand_bits(1) != 0) begin
            m1_r_data  = rand_bits(32);
            m1_r_last  = (r_beat1 == int'(r_lens1[0]));
            m1_r_valid = 1'b1;
         end
      end
   endtask

   // Everything issued, delivered and answered
   function automatic bit traffic_done();
      return aw_sent == N_WR && ar_sent == N_RD && w_lens.size() == 0
         && !s_aw_valid && !s_w_valid && !s_ar_valid && !s_r_valid && !s_b_valid
         && exp_aw0.size() == 0 && exp_aw1.size() == 0
         && exp_ar0.size() == 0 && exp_ar1.size() == 0
         && exp_w0.size() == 0 && exp_w1.size() == 0
         && got_r0.size() == 0 && got_r1.size() == 0
         && r_lens0.size() == 0 && r_lens1.size() == 0
         && !m0_r_valid && !m1_r_valid && !m0_b_valid && !m1_b_valid
         && b_pend0 == 0 && b_pend1 == 0;
   endfunction

   // ====================
   // Main sequence
   // ====================
   initial begin
      lfsr        = 32'hd7d3_ebae;
      resetn      = 1'b0;
      s_aw_addr   = '0;
      s_aw_len    = '0;
      s_aw_valid  = 1'b0;
      s_w_data    = '0;
      s_w_last    = 1'b0;
      s_w_valid   = 1'b0;
      s_b_ready   = 1'b0;
      s_ar_addr   = '0;
      s_ar_len    = '0;
      s_ar_valid  = 1'b0;
      s_r_ready   = 1'b0;
      m0_aw_ready = 1'b0;
      m1_aw_ready = 1'b0;
      m0_w_ready  = 1'b0;
      m1_w_ready  = 1'b0;
      m0_ar_ready = 1'b0;
      m1_ar_ready = 1'b0;
      m0_b_valid  = 1'b0;
      m1_b_valid  = 1'b0;
      m0_r_data   = '0;
      m1_r_data   = '0;
      m0_r_last   = 1'b0;
      m1_r_last   = 1'b0;
      m0_r_valid  = 1'b0;
      m1_r_valid  = 1'b0;
      s_aw_fire   = 1'b0;
      s_w_fire    = 1'b0;
      s_ar_fire   = 1'b0;
      m0_b_fire   = 1'b0;
      m1_b_fire   = 1'b0;
      m0_r_fire   = 1'b0;
      m1_r_fire   = 1'b0;

      repeat (16) begin
         @(negedge clk);
         check_reset_outputs();
      end
      @(posedge clk);
      #1;
      resetn = 1'b1;
      drive_cycle();

      cycles = 0;
      while (!traffic_done() && cycles < TIMEOUT_CYCLES) begin
         @(negedge clk);
         monitor_cycle();
         @(posedge clk);
         #1;
         drive_cycle();
         cycles++;
      end

      if (!traffic_done()) begin
         stop_on_error($sformatf("traffic still pending after %0d cycles", TIMEOUT_CYCLES));
      end else begin
         check_count("slave B responses", sb_cnt, N_WR);
         check_count("m0 B responses", mb_cnt0, N_WR);
         check_count("m1 B responses", mb_cnt1, N_WR);
         check_count("slave R beats", sr_cnt, sr_exp);
         $display("STATUS: PASS");
         $finish;
      end
   end

endmodule

// ==== axi_split_top.f ====
axi_split_pkg.sv
axi_split_fifo.sv
axi_split_addr_fanout.sv
axi_split_wdata_fanout.sv
axi_split_bresp_merge.sv
axi_split_rdata_join.sv
axi_split_top.sv
tb_axi_split.sv

// ==== Makefile ====
# Verilator build, run and lint for the AXI4 splitter

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_axi_split -f axi_split_top.f
	@out=$$(./obj_dir/Vtb_axi_split); echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

lint:
	verilator --lint-only --timing -Wall --top-module axi_split_top -f axi_split_top.f

clean:
	rm -rf obj_dir
